//--- pixel_pkg.sv
// pixel and colour types for the video path
// 12-bit renderer pixel, 24-bit output colour, channel widths

`default_nettype none

package pixel_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // channel widths

    // bits per channel coming from the renderer
    localparam int CHANNEL_W = 4;

    // bits per channel on the video output
    localparam int OUT_CHANNEL_W = 8;

    ////////////////////////////////////////////////////////////////////////////
    // pixel types

    // renderer pixel, red in the top nibble
    typedef struct packed {
        logic [CHANNEL_W-1:0] red;
        logic [CHANNEL_W-1:0] green;
        logic [CHANNEL_W-1:0] blue;
    } src_pixel_t;

    // output colour, one byte per channel, red in the top byte
    typedef struct packed {
        logic [OUT_CHANNEL_W-1:0] red;
        logic [OUT_CHANNEL_W-1:0] green;
        logic [OUT_CHANNEL_W-1:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

//--- pixel_unpack.sv
// renderer pixel unpacker
// samples the 12-bit pixel each clock and widens it to 24-bit colour,
// every nibble placed in the upper half of its byte

`timescale 1ns/1ns
`default_nettype none

module pixel_unpack (
    input  logic                    audgen_mclk,
    input  logic                    reset_n,
    input  pixel_pkg::src_pixel_t   pixel_in,
    video_stage_if.pixel_src        stage
);

    import pixel_pkg::*;

    // low bits filled with zero
    localparam int PAD_W = OUT_CHANNEL_W - CHANNEL_W;

    // nibble to byte, nibble on top
    function automatic logic [OUT_CHANNEL_W-1:0] widen(input logic [CHANNEL_W-1:0] chan);
        widen = {chan, {PAD_W{1'b0}}};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // channel split

    rgb_t wide_colour;

    always_comb begin
        wide_colour.red   = widen(pixel_in.red);
        wide_colour.green = widen(pixel_in.green);
        wide_colour.blue  = widen(pixel_in.blue);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage-1 register

    // sampled on the same edge as the timing strobes
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            stage.colour <= '0;
        end else begin
            stage.colour <= wide_colour;
        end
    end

endmodule

`default_nettype wire

//--- raster_core.f
+incdir+.
video_timing_pkg.sv
pixel_pkg.sv
video_stage_if.sv
raster_timing.sv
pixel_unpack.sv
video_output.sv
raster_core.sv
raster_core_tb.sv

//--- raster_core.sv
// raster video generator top level
// timing generator and pixel unpacker side by side,
// joined through the stage-1 bundle into the output stage

`timescale 1ns/1ns
`default_nettype none

module raster_core #(
    // horizontal timing, in pixel clocks
    parameter video_timing_pkg::coord_t H_BPORCH = video_timing_pkg::DEF_H_BPORCH,
    parameter video_timing_pkg::coord_t H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter video_timing_pkg::coord_t H_TOTAL  = video_timing_pkg::DEF_H_TOTAL,
    // vertical timing, in lines
    parameter video_timing_pkg::coord_t V_BPORCH = video_timing_pkg::DEF_V_BPORCH,
    parameter video_timing_pkg::coord_t V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter video_timing_pkg::coord_t V_TOTAL  = video_timing_pkg::DEF_V_TOTAL
) (
    // pixel clock
    input  logic                            audgen_mclk,
    input  logic                            reset_n,

    // renderer pixel, 4 bits per channel
    input  pixel_pkg::src_pixel_t           pixel_in,

    // to the scaler
    output pixel_pkg::rgb_t                 video_rgb,
    output logic                            video_de,
    output logic                            video_vs,
    output logic                            video_hs,

    // frames since reset
    output video_timing_pkg::frame_count_t  frame_count
);

    ////////////////////////////////////////////////////////////////////////////
    // stage-1 bundle

    video_stage_if stage_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // stage 1

    // counters and strobes
    raster_timing #(
        .H_BPORCH (H_BPORCH),
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_BPORCH (V_BPORCH),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_raster_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .stage       (stage_bus.timing_src)
    );

    // pixel widening, runs alongside the timing
    pixel_unpack u_pixel_unpack (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel_in    (pixel_in),
        .stage       (stage_bus.pixel_src)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stage 2

    // final registers and frame count
    video_output u_video_output (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .stage       (stage_bus.sink),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .frame_count (frame_count)
    );

endmodule

`default_nettype wire

//--- raster_core_tb_tasks.svh
// value check and directed tests for the raster core testbench
// reset, frame sync and counter, line sync, active window, pixel path

`ifndef RASTER_CORE_TB_TASKS_SVH
`define RASTER_CORE_TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t",
                 name, actual, expected, $time);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    end
endtask

task automatic check_idle_outputs();
    check_value("video_de", video_de, 0);
    check_value("video_vs", video_vs, 0);
    check_value("video_hs", video_hs, 0);
    check_value("video_rgb", video_rgb, 0);
    check_value("frame_count", frame_count, 0);
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests

task automatic test_reset();
    rst_drive = 1'b0;
    repeat (3) begin
        next_cycle();
        check_idle_outputs();
    end
    // released just after the fourth edge
    rst_drive = 1'b1;
    next_cycle();
    check_idle_outputs();
    // first edge out of reset, pipeline still empty
    next_cycle();
    check_idle_outputs();
endtask

task automatic test_frame_sync();
    int pulses;
    int since_vs;
    pulses   = 0;
    since_vs = 0;
    while (pulses < 3) begin
        next_cycle();
        since_vs++;
        check_value("video_vs", video_vs, exp_vs);
        check_value("frame_count", frame_count, exp_frames);
        if (video_vs) begin
            pulses++;
            // count steps on the vs edge itself
            check_value("frame_count", frame_count, pulses);
            if (pulses > 1) begin
                check_value("vs period", since_vs, FRAME_CYCLES);
            end
            since_vs = 0;
        end
    end
endtask

task automatic test_line_sync();
    int   pulses;
    logic hs_prev;
    pulses  = 0;
    hs_prev = 1'b0;
    // a whole frame, so the vs cycle falls inside
    repeat (FRAME_CYCLES) begin
        next_cycle();
        check_value("video_hs", video_hs, exp_hs);
        check_value("video_hs with video_vs", video_hs & video_vs, 0);
        check_value("video_hs width", video_hs & hs_prev, 0);
        if (video_hs) begin
            pulses++;
        end
        hs_prev = video_hs;
    end
    check_value("hs pulses in one frame", pulses, V_TOTAL);
endtask

task automatic test_active_window();
    int line_de;
    int frame_de;
    int line_exp;
    line_de  = 0;
    frame_de = 0;
    // start counting on a line boundary
    while (!(pos_valid[2] && pos_x[2] == H_TOTAL - 1)) begin
        next_cycle();
    end
    repeat (FRAME_CYCLES) begin
        next_cycle();
        check_value("video_de", video_de, exp_de);
        line_de += video_de;
        if (pos_x[2] == H_TOTAL - 1) begin
            line_exp = (pos_y[2] >= V_BPORCH && pos_y[2] < V_BPORCH + V_ACTIVE) ?
                       H_ACTIVE : 0;
            check_value("de cycles in line", line_de, line_exp);
            frame_de += line_de;
            line_de  = 0;
        end
    end
    check_value("de cycles in frame", frame_de, H_ACTIVE * V_ACTIVE);
endtask

task automatic test_pixel_path();
    int de_cycles;
    de_cycles  = 0;
    pix_random = 1'b1;
    repeat (FRAME_CYCLES) begin
        next_cycle();
        check_value("video_de", video_de, exp_de);
        check_value("video_rgb", video_rgb, exp_rgb);
        // lower nibble of every byte stays clear
        check_value("video_rgb low nibbles", video_rgb & 24'h0f0f0f, 0);
        if (video_de) begin
            de_cycles++;
        end
    end
    pix_random = 1'b0;
    check_value("de cycles with pixels", de_cycles, H_ACTIVE * V_ACTIVE);
endtask

`endif

//--- raster_core_tb.sv
// testbench for the raster video generator
// clock, reset, timeout, DUT instance, reference model and test sequence

`timescale 1ns/1ns
`default_nettype none

module raster_core_tb;

    ////////////////////////////////////////////////////////////////////////////
    // small raster so a frame is only a few hundred clocks

    localparam int H_BPORCH = 6;
    localparam int H_ACTIVE = 8;
    localparam int H_TOTAL  = 20;
    localparam int V_BPORCH = 2;
    localparam int V_ACTIVE = 4;
    localparam int V_TOTAL  = 12;
    localparam int HS_POS   = video_timing_pkg::HS_OFFSET;

    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    // frame sync test spans three frames
    // margin adds the line sync, window and pixel frames plus reset and slack
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 3 * FRAME_CYCLES + 100;

    logic        audgen_mclk;
    logic        reset_n;
    logic [11:0] pixel_in;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic [15:0] frame_count;

    // stimulus control
    logic        rst_drive;
    logic        pix_random;
    integer      seed;
    int          cycle_count;

    // reference model, index 0 is the counter now, 2 is two edges back
    int          pos_x [0:2];
    int          pos_y [0:2];
    logic        pos_valid [0:2];
    logic [11:0] drv_hist [0:1];
    logic        exp_de;
    logic        exp_vs;
    logic        exp_hs;
    logic [23:0] exp_rgb;
    int          exp_frames;

    raster_core #(
        .H_BPORCH (H_BPORCH),
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_BPORCH (V_BPORCH),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) i_dut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel_in    (pixel_in),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .frame_count (frame_count)
    );

    // 20 ns pixel clock
    initial begin
        audgen_mclk = 1'b0;
        forever #10 audgen_mclk = ~audgen_mclk;
    end

    // run limit
    always @(posedge audgen_mclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "run stopped by timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // nibble into the top half of each byte
    function automatic logic [23:0] expand_pixel(input logic [11:0] p);
        return {p[11:8], 4'h0, p[7:4], 4'h0, p[3:0], 4'h0};
    endfunction

    function automatic logic in_window(input int x, input int y);
        return (x >= H_BPORCH) && (x < H_BPORCH + H_ACTIVE) &&
               (y >= V_BPORCH) && (y < V_BPORCH + V_ACTIVE);
    endfunction

    // one edge of the raster, rst_seen is reset_n as the DUT saw it
    task automatic advance_model(input logic rst_seen, input logic [11:0] drv);
        if (!rst_seen) begin
            for (int i = 0; i < 3; i++) begin
                pos_x[i]     = 0;
                pos_y[i]     = 0;
                pos_valid[i] = 1'b0;
            end
            exp_frames = 0;
        end else begin
            pos_x[2]     = pos_x[1];
            pos_y[2]     = pos_y[1];
            pos_valid[2] = pos_valid[1];
            pos_x[1]     = pos_x[0];
            pos_y[1]     = pos_y[0];
            pos_valid[1] = 1'b1;
            // x wraps at the line end, y at the frame end
            if (pos_x[0] == H_TOTAL - 1) begin
                pos_x[0] = 0;
                pos_y[0] = (pos_y[0] == V_TOTAL - 1) ? 0 : pos_y[0] + 1;
            end else begin
                pos_x[0] = pos_x[0] + 1;
            end
        end
        exp_de = pos_valid[2] && in_window(pos_x[2], pos_y[2]);
        exp_vs = pos_valid[2] && (pos_x[2] == 0) && (pos_y[2] == 0);
        exp_hs = pos_valid[2] && (pos_x[2] == HS_POS);
        if (exp_vs) begin
            exp_frames = exp_frames + 1;
        end
        // pixel driven two edges back belongs to the lagged position
        exp_rgb     = exp_de ? expand_pixel(drv_hist[1]) : 24'h0;
        drv_hist[1] = drv_hist[0];
        drv_hist[0] = drv;
    endtask

    // drive on the rising edge, sample on the falling edge
    task automatic next_cycle();
        logic        rst_seen;
        logic [31:0] rnd;
        logic [11:0] pix_next;
        @(posedge audgen_mclk);
        rst_seen = reset_n;
        rnd      = $random(seed);
        pix_next = pix_random ? rnd[11:0] : 12'h0;
        reset_n  <= rst_drive;
        pixel_in <= pix_next;
        @(negedge audgen_mclk);
        advance_model(rst_seen, pix_next);
    endtask

    `include "raster_core_tb_tasks.svh"

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        seed        = 32'h5707fe64;
        reset_n     = 1'b0;
        pixel_in    = 12'h0;
        rst_drive   = 1'b0;
        pix_random  = 1'b0;
        cycle_count = 0;
        drv_hist[0] = 12'h0;
        drv_hist[1] = 12'h0;
        advance_model(1'b0, 12'h0);

        test_reset();
        test_frame_sync();
        test_line_sync();
        test_active_window();
        test_pixel_path();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- raster_timing.sv
// raster timing generator
// x and y counters, frame and line strobes, active window flag,
// all registered onto the stage-1 bundle

`timescale 1ns/1ns
`default_nettype none

module raster_timing #(
    parameter video_timing_pkg::coord_t H_BPORCH = video_timing_pkg::DEF_H_BPORCH,
    parameter video_timing_pkg::coord_t H_ACTIVE = video_timing_pkg::DEF_H_ACTIVE,
    parameter video_timing_pkg::coord_t H_TOTAL  = video_timing_pkg::DEF_H_TOTAL,
    parameter video_timing_pkg::coord_t V_BPORCH = video_timing_pkg::DEF_V_BPORCH,
    parameter video_timing_pkg::coord_t V_ACTIVE = video_timing_pkg::DEF_V_ACTIVE,
    parameter video_timing_pkg::coord_t V_TOTAL  = video_timing_pkg::DEF_V_TOTAL
) (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    video_stage_if.timing_src   stage
);

    import video_timing_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // derived limits

    // last position before each counter wraps
    localparam coord_t H_LAST = H_TOTAL - 10'd1;
    localparam coord_t V_LAST = V_TOTAL - 10'd1;

    // first position past the visible window
    localparam coord_t H_END = H_BPORCH + H_ACTIVE;
    localparam coord_t V_END = V_BPORCH + V_ACTIVE;

    ////////////////////////////////////////////////////////////////////////////
    // raster counters

    coord_t h_count;
    coord_t v_count;

    logic   h_wrap;
    logic   v_wrap;

    // end of line and end of frame
    assign h_wrap = (h_count == H_LAST);
    assign v_wrap = (v_count == V_LAST);

    // x runs every clock, y steps once per line
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (h_wrap) begin
                h_count <= '0;
                if (v_wrap) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 10'd1;
                end
            end else begin
                h_count <= h_count + 10'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobe decode

    logic at_frame_origin;
    logic at_line_sync;
    logic h_visible;
    logic v_visible;

    // new frame at the top left corner
    assign at_frame_origin = (h_count == '0) && (v_count == '0);

    // line sync a few clocks in, every line
    assign at_line_sync = (h_count == HS_OFFSET);

    // window test per axis
    assign h_visible = (h_count >= H_BPORCH) && (h_count < H_END);
    assign v_visible = (v_count >= V_BPORCH) && (v_count < V_END);

    ////////////////////////////////////////////////////////////////////////////
    // stage-1 registers

    // one cycle behind the counter position
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            stage.frame_start <= 1'b0;
            stage.line_start  <= 1'b0;
            stage.active      <= 1'b0;
        end else begin
            stage.frame_start <= at_frame_origin;
            stage.line_start  <= at_line_sync;
            // data enable only where both axes are visible
            stage.active      <= h_visible && v_visible;
        end
    end

endmodule

`default_nettype wire

//--- video_output.sv
// video output stage
// registers sync, data enable and colour for the scaler,
// blanks colour outside the active window, counts frames

`timescale 1ns/1ns
`default_nettype none

module video_output (
    input  logic                            audgen_mclk,
    input  logic                            reset_n,
    video_stage_if.sink                     stage,
    output pixel_pkg::rgb_t                 video_rgb,
    output logic                            video_de,
    output logic                            video_vs,
    output logic                            video_hs,
    output video_timing_pkg::frame_count_t  frame_count
);

    import pixel_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // blanking

    rgb_t blanked_colour;

    // inactive screen area is black
    always_comb begin
        if (stage.active) begin
            blanked_colour = stage.colour;
        end else begin
            blanked_colour = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output registers

    // everything one cycle after stage 1
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
        end else begin
            video_rgb <= blanked_colour;
            video_de  <= stage.active;
            // vs leads, hs follows a few clocks later
            video_vs  <= stage.frame_start;
            video_hs  <= stage.line_start;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame counter

    // steps on the same edge that raises vs
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            frame_count <= '0;
        end else if (stage.frame_start) begin
            frame_count <= frame_count + 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- video_stage_if.sv
// stage-1 bundle between the timing generator, the pixel unpacker
// and the output stage, with one modport per side

`timescale 1ns/1ns
`default_nettype none

interface video_stage_if;

    import pixel_pkg::*;

    // raster strobes, one cycle each
    logic frame_start;
    logic line_start;

    // inside the visible window
    logic active;

    // widened renderer pixel
    rgb_t colour;

    // timing generator side
    modport timing_src (
        output frame_start,
        output line_start,
        output active
    );

    // pixel unpacker side
    modport pixel_src (
        output colour
    );

    // output stage reads everything
    modport sink (
        input frame_start,
        input line_start,
        input active,
        input colour
    );

endinterface

`default_nettype wire

//--- video_timing_pkg.sv
// raster timing types shared by the video generator
// counter and frame count types, default raster constants
// and the line position of the horizontal sync pulse

`default_nettype none

package video_timing_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // types

    // width of the x and y raster counters
    localparam int COORD_W = 10;

    // one horizontal or vertical position
    typedef logic [COORD_W-1:0] coord_t;

    // running count of frames, wraps silently
    typedef logic [15:0] frame_count_t;

    ////////////////////////////////////////////////////////////////////////////
    // default raster, 256x240 visible

    // horizontal, in pixel clocks
    localparam coord_t DEF_H_BPORCH = 10'd6;
    localparam coord_t DEF_H_ACTIVE = 10'd256;
    localparam coord_t DEF_H_TOTAL  = 10'd276;

    // vertical, in lines
    localparam coord_t DEF_V_BPORCH = 10'd6;
    localparam coord_t DEF_V_ACTIVE = 10'd240;
    localparam coord_t DEF_V_TOTAL  = 10'd880;

    // hs sits a few clocks into the line so it never lands on the vs cycle
    localparam coord_t HS_OFFSET = 10'd3;

endpackage

`default_nettype wire
